// File: Makefile
TOP_TB  := tb_irq_ctrl
TOP_RTL := irq_ctrl_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP_RTL)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP_TB) -Mdir obj_dir -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// File: bench/tb_irq_ctrl.sv
`timescale 1ns/1ps

module tb_irq_ctrl
    import irq_pkg::*;
();

    localparam int APB_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 50;
    localparam int BURST_LEN   = 20;

    logic              CLOCK_50;
    logic              rst_n;
    logic              key_valid;
    logic [KEY_W-1:0]  key_code;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              irq;

    // Model copies of the registers and the expected dispatch order.
    logic [DATA_W-1:0]   base_model;
    logic [DATA_W-1:0]   vec_model [NUM_IRQ_TYPES];
    irq_entry_t          exp_q [$];
    logic [2*DATA_W-1:0] seen_q [$];
    logic [KEY_W-1:0]    burst [$];
    logic [2*DATA_W-1:0] cmp_seen;
    logic [2*DATA_W-1:0] cmp_exp;
    logic                last_err;
    int                  last_stalls;
    int                  errors;
    int                  checks;
    int                  tests_done;
    int                  test_errors;
    string               cur_test;

    irq_ctrl_top irq_ctrl_top_inst (
        .CLOCK_50    (CLOCK_50),
        .rst_n_i     (rst_n),
        .key_valid_i (key_valid),
        .key_code_i  (key_code),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .irq_o       (irq)
    );

    initial
    begin
        CLOCK_50 = 1'b0;
        forever
        begin
            #50 CLOCK_50 = ~CLOCK_50;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected routine address and value. The address is the code base plus the type's vector.
    function automatic logic [2*DATA_W-1:0] ref_dispatch(input irq_entry_t e);
        return {base_model + vec_model[e.irq_type], e.value};
    endfunction

    function automatic logic [ADDR_W-1:0] vec_addr(input int idx);
        return REG_VECTOR_0 + ADDR_W'(4 * idx);
    endfunction

    task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Observed dispatches are matched against the model in order.
    always @(posedge CLOCK_50)
    begin
        if (seen_q.size() > 0)
        begin
            cmp_seen = seen_q.pop_front();
            if (exp_q.size() == 0)
            begin
                $display("%0t ns: a dispatch happened that the model did not expect", $time);
                errors++;
            end
            else
            begin
                cmp_exp = ref_dispatch(exp_q.pop_front());
                check_eq(cmp_seen[2*DATA_W-1:DATA_W], cmp_exp[2*DATA_W-1:DATA_W], "ISR_ADDR");
                check_eq(cmp_seen[DATA_W-1:0], cmp_exp[DATA_W-1:0], "ISR_VALUE");
            end
        end
    end

    task automatic abort_run(input string reason);
        errors++;
        $display("%0t ns: %s", $time, reason);
        $display("Tests: %0d  checks: %0d  errors: %0d", tests_done, checks, errors);
        $display("Verification failed");
        $finish;
    endtask

    task automatic push_key(input logic [KEY_W-1:0] code);
        irq_entry_t e;
        e.irq_type = IRQ_TYPE_KEY;
        e.value    = {{(DATA_W - KEY_W){1'b0}}, code};
        exp_q.push_back(e);
    endtask

    // Raise data carries the type in bits 1:0 and the value in bits 31:2.
    task automatic push_sw(input logic [DATA_W-1:0] data);
        irq_entry_t e;
        e.irq_type = data[1:0];
        e.value    = data >> 2;
        exp_q.push_back(e);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and key drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        int n;
        n = 0;
        @(posedge CLOCK_50);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLOCK_50);
        penable <= 1'b1;
        // Access phase lasts until the slave is ready.
        @(negedge CLOCK_50);
        while (!pready && n < APB_TIMEOUT)
        begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!pready)
        begin
            abort_run("APB transfer was never completed by the slave");
        end
        else
        begin
            rdata       = prdata;
            last_err    = pslverr;
            last_stalls = n;
            @(posedge CLOCK_50);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        apb_xfer(1'b0, addr, '0, data);
    endtask

    task automatic send_burst();
        foreach (burst[i])
        begin
            @(posedge CLOCK_50);
            key_valid <= 1'b1;
            key_code  <= burst[i];
        end
        @(posedge CLOCK_50);
        key_valid <= 1'b0;
    endtask

    task automatic send_key(input logic [KEY_W-1:0] code);
        burst.delete();
        burst.push_back(code);
        send_burst();
        push_key(code);
    endtask

    task automatic raise_sw(input logic [DATA_W-1:0] data);
        apb_write(REG_SW_RAISE, data);
        push_sw(data);
    endtask

    task automatic wait_irq(input logic level, input bit must, output bit seen);
        int n;
        n = 0;
        @(negedge CLOCK_50);
        while (irq !== level && n < IRQ_TIMEOUT)
        begin
            @(negedge CLOCK_50);
            n++;
        end
        seen = (irq === level);
        if (must && !seen)
        begin
            abort_run($sformatf("irq_o did not go %0s in time", level ? "high" : "low"));
        end
    endtask

    task automatic read_dispatch();
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] value;
        apb_read(REG_ISR_ADDR, addr);
        apb_read(REG_ISR_VALUE, value);
        seen_q.push_back({addr, value});
    endtask

    task automatic end_service();
        bit seen;
        apb_write(REG_EOI, '0);
        wait_irq(1'b0, 1'b1, seen);
    endtask

    task automatic service_dispatches(input int count);
        bit seen;
        repeat (count)
        begin
            wait_irq(1'b1, 1'b1, seen);
            read_dispatch();
            end_service();
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        int n;
        bit extra;
        n = 0;
        while (seen_q.size() > 0 && n < 10)
        begin
            @(negedge CLOCK_50);
            n++;
        end
        // Nothing beyond the modeled entries may reach dispatch.
        wait_irq(1'b1, 1'b0, extra);
        check_eq(DATA_W'(extra), 0, "dispatch beyond the expected ones");
        tests_done++;
        $display("Test %0d (%s): %0s", tests_done, cur_test,
                 (errors == test_errors) ? "ok" : "FAILED");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic verify_reset_state();
        logic [DATA_W-1:0] rd;
        start_test("reset state");
        @(negedge CLOCK_50);
        check_eq(DATA_W'(irq), '0, "irq_o after reset");
        check_eq(DATA_W'(pready), 1, "pready_o after reset");
        check_eq(DATA_W'(pslverr), 0, "pslverr_o after reset");
        apb_read(REG_STATUS, rd);
        // Not in service, queue empty, no overflow.
        check_eq(rd, 32'h0000_0002, "STATUS after reset");
        apb_read(REG_CODE_BASE, rd);
        check_eq(rd, '0, "CODE_BASE after reset");
        for (int i = 0; i < NUM_IRQ_TYPES; i++)
        begin
            apb_read(vec_addr(i), rd);
            check_eq(rd, '0, $sformatf("VECTOR_%0d after reset", i));
        end
        end_test();
    endtask

    task automatic register_readback();
        logic [DATA_W-1:0] rd;
        start_test("register access");
        base_model = $urandom();
        apb_write(REG_CODE_BASE, base_model);
        for (int i = 0; i < NUM_IRQ_TYPES; i++)
        begin
            vec_model[i] = $urandom();
            apb_write(vec_addr(i), vec_model[i]);
        end
        apb_read(REG_CODE_BASE, rd);
        check_eq(rd, base_model, "CODE_BASE readback");
        check_eq(DATA_W'(last_err), 0, "pslverr on CODE_BASE read");
        for (int i = 0; i < NUM_IRQ_TYPES; i++)
        begin
            apb_read(vec_addr(i), rd);
            check_eq(rd, vec_model[i], $sformatf("VECTOR_%0d readback", i));
        end
        apb_read(8'h18, rd);
        check_eq(DATA_W'(last_err), 1, "pslverr on unmapped read");
        end_test();
    endtask

    task automatic single_key_dispatch();
        start_test("single key");
        send_key(KEY_W'($urandom()));
        service_dispatches(exp_q.size());
        end_test();
    endtask

    task automatic mixed_traffic();
        bit seen;
        start_test("mixed keys and raises");
        send_key(KEY_W'($urandom()));
        wait_irq(1'b1, 1'b1, seen);
        repeat (8)
        begin
            if ($urandom() % 2 == 0)
            begin
                send_key(KEY_W'($urandom()));
            end
            else
            begin
                raise_sw($urandom());
            end
        end
        service_dispatches(exp_q.size());
        end_test();
    endtask

    task automatic raise_backpressure();
        bit seen;
        bit stalled;
        start_test("raise back-pressure");
        send_key(KEY_W'($urandom()));
        wait_irq(1'b1, 1'b1, seen);
        // Queued keys hold off the pending raise, so a second raise must wait.
        burst.delete();
        repeat (6)
        begin
            burst.push_back(KEY_W'($urandom()));
        end
        send_burst();
        foreach (burst[i])
        begin
            push_key(burst[i]);
        end
        stalled = 1'b0;
        for (int i = 0; i < 4 && !stalled; i++)
        begin
            raise_sw($urandom());
            stalled = (last_stalls > 0);
        end
        check_eq(DATA_W'(stalled), 1, "raise held off by pready");
        service_dispatches(exp_q.size());
        end_test();
    endtask

    task automatic key_overflow();
        logic [DATA_W-1:0]   rd;
        logic [DATA_W-1:0]   addr;
        logic [DATA_W-1:0]   value;
        logic [2*DATA_W-1:0] exp_pair;
        irq_entry_t          e;
        int                  next;
        bit                  seen;
        start_test("key overflow");
        send_key(KEY_W'($urandom()));
        wait_irq(1'b1, 1'b1, seen);
        burst.delete();
        repeat (BURST_LEN)
        begin
            burst.push_back(KEY_W'($urandom()));
        end
        send_burst();
        for (int i = 0; i < KEY_FIFO_DEPTH; i++)
        begin
            push_key(burst[i]);
        end
        apb_read(REG_STATUS, rd);
        check_eq(DATA_W'(rd[2]), 1, "STATUS overflow bit");
        service_dispatches(exp_q.size());
        // Survivors past the first few must still follow the sent order.
        next = KEY_FIFO_DEPTH;
        wait_irq(1'b1, 1'b0, seen);
        while (seen)
        begin
            apb_read(REG_ISR_ADDR, addr);
            apb_read(REG_ISR_VALUE, value);
            while (next < BURST_LEN && {{(DATA_W - KEY_W){1'b0}}, burst[next]} != value)
            begin
                next++;
            end
            if (next >= BURST_LEN)
            begin
                $display("[ERROR] %0t ns: key %h dispatched out of order", $time, value);
                errors++;
            end
            e.irq_type = IRQ_TYPE_KEY;
            e.value    = value;
            exp_pair   = ref_dispatch(e);
            check_eq(addr, exp_pair[2*DATA_W-1:DATA_W], "ISR_ADDR of late key");
            next++;
            end_service();
            wait_irq(1'b1, 1'b0, seen);
        end
        end_test();
    endtask

    initial
    begin
        void'($urandom(32'h6aec_b55c));
        rst_n     <= 1'b0;
        key_valid <= 1'b0;
        key_code  <= '0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        repeat (2) @(posedge CLOCK_50);
        rst_n <= 1'b1;
        verify_reset_state();
        register_readback();
        single_key_dispatch();
        mixed_traffic();
        raise_backpressure();
        key_overflow();
        $display("Tests: %0d  checks: %0d  errors: %0d", tests_done, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: hw/irq_apb_regs.sv
`timescale 1ns/1ps

module irq_apb_regs
    import irq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    input  logic              in_service_i,
    input  logic              q_empty_i,
    input  logic              overflow_i,
    input  irq_entry_t        active_i,
    input  logic              sw_ack_i,
    output logic              sw_req_o,
    output irq_type_t         sw_type_o,
    output logic [DATA_W-1:0] sw_value_o,
    output logic              eoi_o
);

    logic [DATA_W-1:0] code_base;
    logic [DATA_W-1:0] vectors [NUM_IRQ_TYPES];
    logic [DATA_W-1:0] isr_addr;
    logic [ADDR_W-1:0] vec_off;
    logic              vec_hit;
    irq_type_t         vec_idx;
    logic              addr_ok;
    logic              access;
    logic              wr_en;

    // Vector table window, one word per interrupt type.
    assign vec_off = paddr_i - REG_VECTOR_0;
    assign vec_hit = (paddr_i >= REG_VECTOR_0) && (vec_off[1:0] == 2'b00)
                     && (vec_off[ADDR_W-1:2] < (ADDR_W - 2)'(NUM_IRQ_TYPES));
    assign vec_idx = vec_off[TYPE_W+1:2];

    // Routine address for the entry being serviced.
    assign isr_addr = code_base + vectors[active_i.irq_type];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and read data.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        prdata_o = '0;
        addr_ok  = 1'b1;
        case (paddr_i)
            REG_CODE_BASE: prdata_o = code_base;
            REG_STATUS:
            begin
                prdata_o[STAT_IN_SERVICE] = in_service_i;
                prdata_o[STAT_Q_EMPTY]    = q_empty_i;
                prdata_o[STAT_OVERFLOW]   = overflow_i;
            end
            REG_ISR_ADDR:  prdata_o = isr_addr;
            REG_ISR_VALUE: prdata_o = active_i.value;
            REG_SW_RAISE:  prdata_o = '0;
            REG_EOI:       prdata_o = '0;
            default:
            begin
                addr_ok = vec_hit;
                if (vec_hit)
                begin
                    prdata_o = vectors[vec_idx];
                end
            end
        endcase
    end

    assign access = psel_i && penable_i;

    // A second raise stalls until the previous one is taken.
    assign pready_o  = !(access && pwrite_i && (paddr_i == REG_SW_RAISE)
                         && sw_req_o && !sw_ack_i);
    assign pslverr_o = access && !addr_ok;
    assign wr_en     = access && pwrite_i && pready_o && addr_ok;
    assign eoi_o     = wr_en && (paddr_i == REG_EOI);

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            code_base <= '0;
            sw_req_o  <= 1'b0;
            for (int i = 0; i < NUM_IRQ_TYPES; i++)
            begin
                vectors[i] <= '0;
            end
        end
        else
        begin
            if (wr_en && paddr_i == REG_CODE_BASE)
            begin
                code_base <= pwdata_i;
            end
            if (wr_en && vec_hit)
            begin
                vectors[vec_idx] <= pwdata_i;
            end
            if (wr_en && paddr_i == REG_SW_RAISE)
            begin
                sw_req_o <= 1'b1;
            end
            else if (sw_ack_i)
            begin
                sw_req_o <= 1'b0;
            end
        end
    end

    // Raise payload: type in the low bits, value in the rest.
    always_ff @(posedge clk_i)
    begin
        if (wr_en && paddr_i == REG_SW_RAISE)
        begin
            sw_type_o  <= pwdata_i[TYPE_W-1:0];
            sw_value_o <= DATA_W'(pwdata_i[DATA_W-1:TYPE_W]);
        end
    end

    // A stalled transfer must be held by the host until it completes.
    a_apb_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (access && !pready_o) |=> access && $stable(paddr_i) && $stable(pwrite_i));

endmodule

// File: hw/irq_ctrl_top.sv
`timescale 1ns/1ps

module irq_ctrl_top
    import irq_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              rst_n_i,
    input  logic              key_valid_i,
    input  logic [KEY_W-1:0]  key_code_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              irq_o
);

    logic              q_wr;
    irq_entry_t        q_entry;
    logic              q_full;
    logic              q_rd;
    irq_entry_t        q_head;
    logic              q_empty;
    irq_entry_t        active;
    logic              eoi;
    logic              sw_req;
    irq_type_t         sw_type;
    logic [DATA_W-1:0] sw_value;
    logic              sw_ack;
    logic              overflow;

    irq_source irq_source_inst (
        .clk_i       (CLOCK_50),
        .rst_n_i     (rst_n_i),
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .sw_req_i    (sw_req),
        .sw_type_i   (sw_type),
        .sw_value_i  (sw_value),
        .q_full_i    (q_full),
        .sw_ack_o    (sw_ack),
        .q_wr_o      (q_wr),
        .q_entry_o   (q_entry),
        .overflow_o  (overflow)
    );

    // Interrupt queue of type/value pairs.
    sync_fifo #(
        .T     (irq_entry_t),
        .DEPTH (IRQ_QUEUE_DEPTH)
    ) irq_queue_inst (
        .clk_i   (CLOCK_50),
        .rst_n_i (rst_n_i),
        .wr_i    (q_wr),
        .data_i  (q_entry),
        .rd_i    (q_rd),
        .data_o  (q_head),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

    irq_dispatcher irq_dispatcher_inst (
        .clk_i        (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .q_empty_i    (q_empty),
        .q_entry_i    (q_head),
        .eoi_i        (eoi),
        .q_rd_o       (q_rd),
        .in_service_o (irq_o),
        .active_o     (active)
    );

    irq_apb_regs irq_apb_regs_inst (
        .clk_i        (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .in_service_i (irq_o),
        .q_empty_i    (q_empty),
        .overflow_i   (overflow),
        .active_i     (active),
        .sw_ack_i     (sw_ack),
        .sw_req_o     (sw_req),
        .sw_type_o    (sw_type),
        .sw_value_o   (sw_value),
        .eoi_o        (eoi)
    );

endmodule

// File: hw/irq_dispatcher.sv
`timescale 1ns/1ps

module irq_dispatcher
    import irq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       q_empty_i,
    input  irq_entry_t q_entry_i,
    input  logic       eoi_i,
    output logic       q_rd_o,
    output logic       in_service_o,
    output irq_entry_t active_o
);

    typedef enum logic [1:0] {
        DSP_READ,
        DSP_WAIT,
        DSP_CAPTURE
    } dsp_state_t;

    dsp_state_t state;

    // Pop only when idle and no routine is running.
    assign q_rd_o = (state == DSP_READ) && !in_service_o && !q_empty_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read, wait, capture.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state        <= DSP_READ;
            in_service_o <= 1'b0;
        end
        else
        begin
            case (state)
                DSP_READ:
                begin
                    if (q_rd_o)
                    begin
                        state <= DSP_WAIT;
                    end
                end
                DSP_WAIT:
                begin
                    state <= DSP_CAPTURE;
                end
                DSP_CAPTURE:
                begin
                    state <= DSP_READ;
                end
                default:
                begin
                    state <= DSP_READ;
                end
            endcase
            // Capture starts service; EOI ends it.
            if (state == DSP_CAPTURE)
            begin
                in_service_o <= 1'b1;
            end
            else if (eoi_i)
            begin
                in_service_o <= 1'b0;
            end
        end
    end

    // Head entry taken at the pop edge and held through service.
    always_ff @(posedge clk_i)
    begin
        if (q_rd_o)
        begin
            active_o <= q_entry_i;
        end
    end

    // Service lasts until EOI and nothing is popped meanwhile.
    a_no_pop_in_service : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_service_o && !eoi_i |=> in_service_o && !q_rd_o);
    // Read and wait cycles, then service starts after the capture.
    a_pop_to_service : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        q_rd_o |=> !q_rd_o ##1 !in_service_o ##1 in_service_o);

endmodule

// File: hw/irq_pkg.sv
package irq_pkg;

    // Word and scancode widths.
    localparam int DATA_W = 32;
    localparam int KEY_W  = 8;
    localparam int ADDR_W = 8;

    // One vector-table entry per interrupt type.
    localparam int NUM_IRQ_TYPES = 4;
    localparam int TYPE_W        = $clog2(NUM_IRQ_TYPES);

    typedef logic [TYPE_W-1:0] irq_type_t;

    localparam irq_type_t IRQ_TYPE_KEY = irq_type_t'(0);

    // Interrupt queue entry, type and value kept together.
    typedef struct packed {
        irq_type_t         irq_type;
        logic [DATA_W-1:0] value;
    } irq_entry_t;

    localparam int KEY_FIFO_DEPTH  = 5;
    localparam int IRQ_QUEUE_DEPTH = 10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [ADDR_W-1:0] REG_CODE_BASE = 8'h00;
    localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h04;
    localparam logic [ADDR_W-1:0] REG_ISR_ADDR  = 8'h08;
    localparam logic [ADDR_W-1:0] REG_ISR_VALUE = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_SW_RAISE  = 8'h10;
    localparam logic [ADDR_W-1:0] REG_EOI       = 8'h14;
    localparam logic [ADDR_W-1:0] REG_VECTOR_0  = 8'h20;

    // Status register bit positions.
    localparam int STAT_IN_SERVICE = 0;
    localparam int STAT_Q_EMPTY    = 1;
    localparam int STAT_OVERFLOW   = 2;

endpackage

// File: hw/irq_source.sv
`timescale 1ns/1ps

module irq_source
    import irq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              key_valid_i,
    input  logic [KEY_W-1:0]  key_code_i,
    input  logic              sw_req_i,
    input  irq_type_t         sw_type_i,
    input  logic [DATA_W-1:0] sw_value_i,
    input  logic              q_full_i,
    output logic              sw_ack_o,
    output logic              q_wr_o,
    output irq_entry_t        q_entry_o,
    output logic              overflow_o
);

    typedef enum logic [0:0] {
        SRC_IDLE,
        SRC_KEY_WRITE
    } src_state_t;

    src_state_t       state;
    logic             key_wr;
    logic             key_rd;
    logic             key_empty;
    logic             key_full;
    logic [KEY_W-1:0] key_head;
    logic [KEY_W-1:0] key_byte;

    // Bytes arriving on a full buffer are lost.
    assign key_wr = key_valid_i && !key_full;

    sync_fifo #(
        .T     (logic [KEY_W-1:0]),
        .DEPTH (KEY_FIFO_DEPTH)
    ) key_fifo_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (key_wr),
        .data_i  (key_code_i),
        .rd_i    (key_rd),
        .data_o  (key_head),
        .empty_o (key_empty),
        .full_o  (key_full)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue write arbitration. Keys win over software requests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        key_rd             = 1'b0;
        sw_ack_o           = 1'b0;
        q_wr_o             = 1'b0;
        q_entry_o.irq_type = sw_type_i;
        q_entry_o.value    = sw_value_i;
        case (state)
            SRC_IDLE:
            begin
                if (!q_full_i)
                begin
                    if (!key_empty)
                    begin
                        key_rd = 1'b1;
                    end
                    else if (sw_req_i)
                    begin
                        q_wr_o   = 1'b1;
                        sw_ack_o = 1'b1;
                    end
                end
            end
            SRC_KEY_WRITE:
            begin
                q_entry_o.irq_type = IRQ_TYPE_KEY;
                q_entry_o.value    = {{(DATA_W - KEY_W){1'b0}}, key_byte};
                q_wr_o             = !q_full_i;
            end
            default:
            begin
                q_wr_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state      <= SRC_IDLE;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (key_rd)
            begin
                state <= SRC_KEY_WRITE;
            end
            else if (state == SRC_KEY_WRITE && q_wr_o)
            begin
                state <= SRC_IDLE;
            end
            // Sticky until reset.
            if (key_valid_i && key_full)
            begin
                overflow_o <= 1'b1;
            end
        end
    end

    // Popped scancode held for the write cycle.
    always_ff @(posedge clk_i)
    begin
        if (key_rd)
        begin
            key_byte <= key_head;
        end
    end

    // A software request and its payload stay put until this block takes it.
    a_req_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sw_req_i && !sw_ack_o |=> sw_req_i && $stable(sw_type_i) && $stable(sw_value_i));
    // Only this block fills the queue, so a popped key always lands next cycle.
    a_key_pop_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        key_rd |=> q_wr_o && (q_entry_o.irq_type == IRQ_TYPE_KEY));

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic wr_i,
    input  T     data_i,
    input  logic rd_i,
    output T     data_o,
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign do_wr   = wr_i && !full_o;
    assign do_rd   = rd_i && !empty_o;

    // Head of the buffer; moves to the next entry at the pop edge.
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk_i)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two.
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer and consumer around this FIFO must respect its flags.
    a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_i |-> !full_o);
    a_no_read_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_i |-> !empty_o);

endmodule

// File: list.f
hw/irq_pkg.sv
hw/sync_fifo.sv
hw/irq_source.sv
hw/irq_dispatcher.sv
hw/irq_apb_regs.sv
hw/irq_ctrl_top.sv
bench/tb_irq_ctrl.sv
